//--- compile.f
logic/rv_pkg.sv
logic/core_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv_core.sv
verif/core_assert.sv
verif/core_checker.sv
verif/core_tb.sv

//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;   // instruction port never writes.
        logic [31:0] adr;
    } wb_request_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_response_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_out_t;

    typedef struct packed {
        logic                 valid;
        logic [31:0]          pc;
        logic [31:0]          operand_a;
        logic [31:0]          operand_b;  // holds rs1 for jalr.
        logic [31:0]          rs2_data;
        logic [4:0]           rd;
        rv_pkg::alu_op_t      alu_op;
        rv_pkg::branch_op_t   branch_op;
        logic                 is_jal;
        logic                 is_jalr;
        logic                 writes_rd;
        logic                 illegal;
        logic [31:0]          imm;
    } decode_out_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } write_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        wrote;
        logic        illegal;
    } retire_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_busy,
        fetch_discard
    } fetch_state_t;

endpackage

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  core_pkg::fetch_out_t  fetch_out,
    input  core_pkg::redirect_t   redirect,
    input  logic [31:0]           rs1_data,
    input  logic [31:0]           rs2_data,
    output logic [4:0]            rs1_addr,
    output logic [4:0]            rs2_addr,
    output core_pkg::decode_out_t decode_out
);
    import rv_pkg::*;
    import core_pkg::*;

    instr_t      fields;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        reg_op;
    logic        alt_funct;
    logic        legal;
    decode_out_t next;

    assign fields = instr_t'(fetch_out.instr);
    assign rs1_addr = fields.rs1;
    assign rs2_addr = fields.rs2;

    assign imm_i = {{20{fetch_out.instr[31]}}, fetch_out.instr[31:20]};
    assign imm_u = {fetch_out.instr[31:12], 12'b0};
    assign imm_b = {{20{fetch_out.instr[31]}}, fetch_out.instr[7], fetch_out.instr[30:25],
                    fetch_out.instr[11:8], 1'b0};
    assign imm_j = {{12{fetch_out.instr[31]}}, fetch_out.instr[19:12], fetch_out.instr[20],
                    fetch_out.instr[30:21], 1'b0};

    assign reg_op = (fields.opcode == opc_op);
    // sub and sra are the only encodings with funct7 set to 0100000.
    assign alt_funct = (reg_op && fields.funct3 == 3'b000) || fields.funct3 == 3'b101;

    always_comb begin
        next = '0;
        next.valid = fetch_out.valid;
        next.pc = fetch_out.pc;
        next.rd = fields.rd;
        next.rs2_data = rs2_data;
        next.operand_a = rs1_data;
        next.operand_b = rs2_data;
        next.alu_op = alu_add;
        next.branch_op = br_none;
        legal = 1'b1;
        case (fields.opcode)
            opc_lui: begin
                next.operand_a = '0;
                next.operand_b = imm_u;
                next.imm = imm_u;
                next.alu_op = alu_pass_b;
            end
            opc_auipc: begin
                next.operand_a = fetch_out.pc;
                next.operand_b = imm_u;
                next.imm = imm_u;
            end
            opc_jal: begin
                next.operand_a = fetch_out.pc;
                next.operand_b = imm_j;
                next.imm = imm_j;
                next.is_jal = 1'b1;
            end
            opc_jalr: begin
                next.operand_a = fetch_out.pc;
                next.operand_b = rs1_data;  // base of the jump target.
                next.imm = imm_i;
                next.is_jalr = 1'b1;
                legal = (fields.funct3 == 3'b000);
            end
            opc_branch: begin
                next.imm = imm_b;
                case (fields.funct3)
                    3'b000: next.branch_op = br_beq;
                    3'b001: next.branch_op = br_bne;
                    3'b100: next.branch_op = br_blt;
                    3'b101: next.branch_op = br_bge;
                    3'b110: next.branch_op = br_bltu;
                    3'b111: next.branch_op = br_bgeu;
                    default: legal = 1'b0;
                endcase
            end
            opc_op_imm, opc_op: begin
                if (!reg_op) begin
                    next.operand_b = imm_i;
                    next.imm = imm_i;
                end
                case (fields.funct3)
                    3'b000: next.alu_op = (reg_op && fields.funct7[5]) ? alu_sub : alu_add;
                    3'b001: next.alu_op = alu_sll;
                    3'b010: next.alu_op = alu_slt;
                    3'b011: next.alu_op = alu_sltu;
                    3'b100: next.alu_op = alu_xor;
                    3'b101: next.alu_op = fields.funct7[5] ? alu_sra : alu_srl;
                    3'b110: next.alu_op = alu_or;
                    3'b111: next.alu_op = alu_and;
                endcase
                if (reg_op || fields.funct3 == 3'b001 || fields.funct3 == 3'b101) begin
                    legal = (fields.funct7 == 7'b0000000) ||
                            (alt_funct && fields.funct7 == 7'b0100000);
                end
            end
            default: legal = 1'b0;
        endcase
        next.illegal = ~legal;
        next.writes_rd = legal && fields.opcode != opc_branch && fields.rd != 5'd0;
    end

    always_ff @(posedge clock) begin
        decode_out <= next;
        if (reset == 1'b0 || redirect.valid) begin
            decode_out.valid <= 1'b0;  // wrong-path word in fetch_out is dropped here.
        end
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  core_pkg::decode_out_t decode_out,
    output core_pkg::redirect_t   redirect,
    output core_pkg::write_t      write
);
    import rv_pkg::*;
    import core_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_result;
    logic [31:0] link;
    logic [31:0] target_sum;
    logic        taken;
    logic        jump;

    assign op_a = decode_out.operand_a;
    assign op_b = decode_out.operand_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (decode_out.alu_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_sll: alu_result = op_a << shamt;
            alu_slt: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {31'b0, op_a < op_b};
            alu_xor: alu_result = op_a ^ op_b;
            alu_srl: alu_result = op_a >> shamt;
            alu_sra: alu_result = $unsigned($signed(op_a) >>> shamt);
            alu_or: alu_result = op_a | op_b;
            alu_and: alu_result = op_a & op_b;
            default: alu_result = op_b;
        endcase
    end

    // branches compare rs1 against rs2, never against the immediate.
    always_comb begin
        case (decode_out.branch_op)
            br_beq: taken = (op_a == decode_out.rs2_data);
            br_bne: taken = (op_a != decode_out.rs2_data);
            br_blt: taken = ($signed(op_a) < $signed(decode_out.rs2_data));
            br_bge: taken = ($signed(op_a) >= $signed(decode_out.rs2_data));
            br_bltu: taken = (op_a < decode_out.rs2_data);
            br_bgeu: taken = (op_a >= decode_out.rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign jump = decode_out.is_jal | decode_out.is_jalr;
    assign link = decode_out.pc + 32'd4;
    assign target_sum = (decode_out.is_jalr ? op_b : decode_out.pc) + decode_out.imm;

    assign redirect.valid = decode_out.valid & (jump | taken);
    assign redirect.target = {target_sum[31:1], target_sum[0] & ~decode_out.is_jalr};

    assign write.valid = decode_out.valid & decode_out.writes_rd;
    assign write.rd = decode_out.rd;
    assign write.data = jump ? link : alu_result;

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter logic [31:0] reset_address = 32'h0000_0000
) (
    input  logic                  clock,
    input  logic                  reset,
    input  core_pkg::wb_response_t wb_response,
    input  core_pkg::redirect_t   redirect,
    output core_pkg::wb_request_t wb_request,
    output core_pkg::fetch_out_t  fetch_out
);
    import core_pkg::*;

    fetch_state_t state;
    logic [31:0]  pc;      // address of the request on the bus.
    logic [31:0]  target;  // where to go once the discarded word has arrived.
    logic         accept;

    // the cycle stays open in busy and discard, so adr only moves after an ack.
    assign wb_request.cyc = (state != fetch_idle);
    assign wb_request.stb = (state != fetch_idle);
    assign wb_request.we = 1'b0;
    assign wb_request.adr = pc;
    assign accept = wb_request.stb & wb_response.ack;

    always_ff @(posedge clock) begin
        if (reset == 1'b0) begin
            state <= fetch_idle;
            pc <= reset_address;
            fetch_out.valid <= 1'b0;
        end else begin
            fetch_out.valid <= 1'b0;
            case (state)
                fetch_idle: begin
                    state <= fetch_busy;
                end
                fetch_busy: begin
                    if (redirect.valid) begin
                        if (accept) begin
                            pc <= redirect.target;  // the word just acked is wrong path.
                        end else begin
                            target <= redirect.target;
                            state <= fetch_discard;
                        end
                    end else if (accept) begin
                        fetch_out.valid <= 1'b1;
                        fetch_out.pc <= pc;
                        fetch_out.instr <= wb_response.dat;
                        pc <= pc + 32'd4;
                    end
                end
                fetch_discard: begin
                    if (accept) begin
                        pc <= target;
                        state <= fetch_busy;
                    end
                end
                default: begin
                    state <= fetch_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  core_pkg::write_t      write,
    input  core_pkg::decode_out_t decode_out,
    input  logic [4:0]            rs1_addr,
    input  logic [4:0]            rs2_addr,
    output logic [31:0]           rs1_data,
    output logic [31:0]           rs2_data,
    output core_pkg::retire_t     retire
);
    import core_pkg::*;

    logic [31:0] regs [1:31];  // x0 has no storage.

    // a write in this cycle is visible to decode at once.
    function automatic logic [31:0] read_port(input logic [4:0] addr, input logic [31:0] stored,
                                              input write_t wr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wr.valid && wr.rd == addr) begin
            return wr.data;
        end
        return stored;
    endfunction

    assign rs1_data = read_port(rs1_addr, regs[rs1_addr], write);
    assign rs2_data = read_port(rs2_addr, regs[rs2_addr], write);

    always_ff @(posedge clock) begin
        if (write.valid && write.rd != 5'd0) begin
            regs[write.rd] <= write.data;
        end
    end

    always_ff @(posedge clock) begin
        retire.pc <= decode_out.pc;
        retire.illegal <= decode_out.illegal;
        retire.rd <= write.rd;
        retire.data <= write.data;
        retire.wrote <= write.valid;
        if (reset == 1'b0) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= decode_out.valid;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter logic [31:0] reset_address = 32'h0000_0000
) (
    input  logic                   clock,
    input  logic                   reset,
    input  core_pkg::wb_response_t wb_response,
    output core_pkg::wb_request_t  wb_request,
    output core_pkg::retire_t      retire
);
    import core_pkg::*;

    fetch_out_t  fetch_out;
    decode_out_t decode_out;
    redirect_t   redirect;
    write_t      write;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    fetch_stage #(
        .reset_address(reset_address)
    ) i_fetch_stage (
        .clock(clock),
        .reset(reset),
        .wb_response(wb_response),
        .redirect(redirect),
        .wb_request(wb_request),
        .fetch_out(fetch_out)
    );

    decode_stage i_decode_stage (
        .clock(clock),
        .reset(reset),
        .fetch_out(fetch_out),
        .redirect(redirect),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .decode_out(decode_out)
    );

    execute_stage i_execute_stage (
        .decode_out(decode_out),
        .redirect(redirect),
        .write(write)
    );

    result_stage i_result_stage (
        .clock(clock),
        .reset(reset),
        .write(write),
        .decode_out(decode_out),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .retire(retire)
    );

endmodule

`default_nettype wire

//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b  // lui only.
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } branch_op_t;

    // r-type field layout. the other formats reuse these bit positions.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } instr_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module core_tb -Mdir obj_dir -o core_sim -f compile.f \
    && ./obj_dir/core_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
grep -q "^Testbench passed$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- verif/core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module core_assert (
    input logic                   clock,
    input logic                   reset,
    input core_pkg::wb_request_t  wb_request,
    input core_pkg::wb_response_t wb_response,
    input core_pkg::retire_t      retire
);
    stb_needs_cyc: assert property (@(posedge clock) disable iff (reset == 1'b0)
        wb_request.stb |-> wb_request.cyc)
        else $error("stb asserted without cyc");

    // a request without ack must hold its address.
    adr_held: assert property (@(posedge clock) disable iff (reset == 1'b0)
        (wb_request.stb && !wb_response.ack) |=> $stable(wb_request.adr))
        else $error("adr changed while a request was pending");

    adr_aligned: assert property (@(posedge clock) disable iff (reset == 1'b0)
        wb_request.stb |-> (wb_request.adr[1:0] == 2'b00))
        else $error("instruction address not word aligned");

    no_x0_write: assert property (@(posedge clock) disable iff (reset == 1'b0)
        (retire.valid && retire.wrote) |-> (retire.rd != 5'd0))
        else $error("retire reports a write to x0");

endmodule

bind rv_core core_assert i_core_assert (
    .clock(clock),
    .reset(reset),
    .wb_request(wb_request),
    .wb_response(wb_response),
    .retire(retire)
);

`default_nettype wire

//--- verif/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
    parameter logic [31:0] base = 32'h0000_0100
) (
    input  logic                  clock,
    input  logic                  reset,
    input  core_pkg::wb_request_t wb_request,
    input  core_pkg::retire_t     retire,
    input  logic [31:0]           program_image [0:63],
    input  int                    test_start [0:6],
    output logic                  done,
    output int                    trace_length,
    output int                    tests_passed,
    output int                    tests_failed
);
    import core_pkg::*;

    string       names [0:6] = '{"reset", "upper_x0", "alu", "branch", "loop", "jump", "illegal"};
    int          errors [0:6] = '{default: 0};
    logic [31:0] m_pc;
    logic [31:0] m_regs [0:31];
    retire_t     want;
    int          t;
    int          steps;
    int          current = 1;
    int          passed = 0;
    int          failed = 0;
    int          late = 0;
    int          trace = 0;
    logic        counted = 1'b0;
    logic        seen_request = 1'b0;
    logic        finished = 1'b0;

    assign done = finished;
    assign trace_length = trace;
    assign tests_passed = passed;
    assign tests_failed = failed + late;

    function automatic logic [31:0] word_at(input logic [31:0] pc);
        logic [31:0] idx;
        idx = (pc - base) >> 2;
        if (idx < 32'd64) begin
            return program_image[idx[5:0]];
        end
        return 32'hffff_ffff;
    endfunction

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes the instruction at m_pc and returns the record it should retire with.
    function automatic retire_t reference_step();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic [2:0]  f3;
        logic        ok;
        logic        wr;
        logic        taken;
        retire_t     r;
        w = word_at(m_pc);
        f3 = w[14:12];
        a = m_regs[w[19:15]];
        b = m_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        ok = 1'b1;
        wr = 1'b1;
        taken = 1'b0;
        val = '0;
        next_pc = m_pc + 32'd4;
        case (w[6:0])
            7'h37: val = {w[31:12], 12'h000};
            7'h17: val = m_pc + {w[31:12], 12'h000};
            7'h6f: begin
                val = m_pc + 32'd4;
                next_pc = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                ok = (f3 == 3'd0);
                val = m_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                ok = (f3 != 3'd2) && (f3 != 3'd3);
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    3'd7: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (ok && taken) begin
                    next_pc = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'h13: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    ok = (w[31:25] == 7'h00) || (f3 == 3'd5 && w[31:25] == 7'h20);
                end
                val = alu(f3, f3 == 3'd5 && w[30], a, imm_i);
            end
            7'h33: begin
                ok = (w[31:25] == 7'h00) || (w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                val = alu(f3, w[30], a, b);
            end
            default: ok = 1'b0;
        endcase
        r = '0;
        r.valid = 1'b1;
        r.pc = m_pc;
        r.rd = w[11:7];
        r.data = val;
        r.illegal = ~ok;
        r.wrote = ok && wr && (w[11:7] != 5'd0);
        if (r.wrote) begin
            m_regs[w[11:7]] = val;
        end
        m_pc = next_pc;
        return r;
    endfunction

    task automatic model_reset();
        m_pc = base;
        for (int k = 0; k < 32; k++) begin
            m_regs[k] = '0;
        end
    endtask

    function automatic int test_of(input logic [31:0] pc);
        int idx;
        idx = int'((pc - base) >> 2);
        for (int k = 6; k >= 1; k--) begin
            if (idx >= test_start[k]) begin
                return k;
            end
        end
        return 1;
    endfunction

    task automatic finish_test(input int id);
        if (errors[id] == 0) begin
            passed++;
            $display("test %s passed", names[id]);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", names[id], errors[id]);
        end
    endtask

    always @(negedge clock) begin
        if (!counted) begin
            model_reset();
            for (steps = 1; steps <= 1000; steps++) begin
                want = reference_step();
                if (word_at(want.pc) == 32'h0000_006f) begin
                    break;
                end
            end
            trace = steps;
            model_reset();
            counted = 1'b1;
        end
        if (!reset && (wb_request.cyc || wb_request.stb)) begin
            $display("ERROR: bus cycle started while reset was asserted");
            errors[0]++;
        end
        if (reset && wb_request.stb && !seen_request) begin
            seen_request = 1'b1;
            if (wb_request.adr != base) begin
                $display("CHECK FAILED reset: expected adr %h, actual adr %h",
                         base, wb_request.adr);
                errors[0]++;
            end
            if (wb_request.we) begin
                $display("CHECK FAILED reset: expected we 0, actual we %b", wb_request.we);
                errors[0]++;
            end
            finish_test(0);
        end
        if (reset && retire.valid) begin
            if (finished) begin
                $display("ERROR: instruction at pc %h retired after the program ended",
                         retire.pc);
                late++;
            end else begin
                want = reference_step();
                t = test_of(want.pc);
                while (current < t) begin
                    finish_test(current);
                    current++;
                end
                if (retire.pc != want.pc || retire.rd != want.rd || retire.wrote != want.wrote
                        || retire.illegal != want.illegal
                        || (want.wrote && retire.data != want.data)) begin
                    $write("CHECK FAILED %s: expected pc %h rd %0d data %h wrote %b illegal %b",
                           names[t], want.pc, want.rd, want.data, want.wrote, want.illegal);
                    $display(", actual pc %h rd %0d data %h wrote %b illegal %b",
                             retire.pc, retire.rd, retire.data, retire.wrote, retire.illegal);
                    errors[t]++;
                end
                if (word_at(want.pc) == 32'h0000_006f) begin  // the closing self-loop.
                    finish_test(current);
                    finished = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam logic [31:0] reset_address = 32'h0000_0100;

    logic         clock = 1'b0;
    logic         reset;
    wb_request_t  wb_request;
    wb_response_t wb_response;
    retire_t      retire;
    logic [31:0]  prog [0:63];
    int           test_start [0:6];
    logic [31:0]  lfsr = 32'h0000_08b4;
    logic [31:0]  draw;
    int           n;
    int           cycles = 0;
    logic         pending;
    logic [1:0]   wait_left;
    logic         done;
    int           trace_length;
    int           tests_passed;
    int           tests_failed;

    always #10 clock = ~clock;

    rv_core #(
        .reset_address(reset_address)
    ) i_rv_core (
        .clock(clock),
        .reset(reset),
        .wb_response(wb_response),
        .wb_request(wb_request),
        .retire(retire)
    );

    core_checker #(
        .base(reset_address)
    ) i_core_checker (
        .clock(clock),
        .reset(reset),
        .wb_request(wb_request),
        .retire(retire),
        .program_image(prog),
        .test_start(test_start),
        .done(done),
        .trace_length(trace_length),
        .tests_passed(tests_passed),
        .tests_failed(tests_failed)
    );

    // fibonacci lfsr with taps 32, 22, 2 and 1. it steps once per bit.
    function automatic logic [31:0] lfsr_take(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int k = 0; k < count; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] adr);
        // low bits 00 mark a compressed encoding, which the core treats as illegal.
        return {adr[31:2] ^ {28'b0, adr[1:0]}, 2'b00};
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] adr);
        logic [31:0] idx;
        idx = (adr - reset_address) >> 2;
        if (idx < 32'd64) begin
            return prog[idx[5:0]];
        end
        return fill_word(adr);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] o, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] o, input logic [4:0] rd);
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[n] = word;
        n = n + 1;
    endtask

    task automatic build_program();
        logic [31:0] r;
        for (int k = 0; k < 64; k++) begin
            prog[k] = fill_word(reset_address + 32'(4 * k));
        end
        n = 0;
        test_start[0] = 0;
        test_start[1] = n;
        r = lfsr_take(20);
        emit({r[19:0], 5'd1, 7'h37});
        r = lfsr_take(20);
        emit({r[19:0], 5'd2, 7'h17});
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));  // add into x0.
        test_start[2] = n;
        r = lfsr_take(12);
        emit(enc_i(r[11:0], 5'd1, 3'd0, 5'd3, 7'h13));
        r = lfsr_take(12);
        emit(enc_i(r[11:0], 5'd3, 3'd0, 5'd4, 7'h13));
        for (int k = 0; k < 8; k++) begin
            emit(enc_r(7'h00, 5'd4, 5'd5, 3'(k), 5'd5));
        end
        emit(enc_r(7'h20, 5'd4, 5'd5, 3'd0, 5'd6));
        emit(enc_r(7'h20, 5'd3, 5'd6, 3'd5, 5'd7));
        for (int k = 0; k < 8; k++) begin
            r = lfsr_take(12);
            if (k == 1 || k == 5) begin
                r[11:5] = 7'h00;
            end
            emit(enc_i(r[11:0], 5'd7, 3'(k), 5'd7, 7'h13));
        end
        r = lfsr_take(5);
        emit(enc_i({7'h20, r[4:0]}, 5'd7, 3'd5, 5'd7, 7'h13));
        test_start[3] = n;
        // each branch skips one addi when taken. the second pass compares equal operands.
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 8; k++) begin
                if (k != 2 && k != 3) begin
                    emit(enc_b(13'd8, (p == 0) ? 5'd4 : 5'd3, 5'd3, 3'(k)));
                    emit(enc_i(12'd1, 5'd8, 3'd0, 5'd8, 7'h13));
                end
            end
        end
        test_start[4] = n;
        emit(enc_i(12'd4, 5'd0, 3'd0, 5'd9, 7'h13));
        emit(enc_i(12'd3, 5'd10, 3'd0, 5'd10, 7'h13));
        emit(enc_i(12'hfff, 5'd9, 3'd0, 5'd9, 7'h13));
        emit(enc_b(13'h1ff8, 5'd0, 5'd9, 3'd1));
        test_start[5] = n;
        emit(enc_j(21'd8, 5'd11));
        emit(enc_i(12'd1, 5'd8, 3'd0, 5'd8, 7'h13));
        emit({20'd0, 5'd12, 7'h17});
        emit(enc_i(12'd12, 5'd12, 3'd0, 5'd13, 7'h67));
        emit(enc_i(12'd1, 5'd8, 3'd0, 5'd8, 7'h13));
        test_start[6] = n;
        emit(32'hffff_ffff);
        emit(enc_j(21'd0, 5'd0));
    endtask

    // wishbone slave. each request waits 0 to 3 cycles before its single-cycle ack.
    initial begin
        wb_response = '0;
        pending = 1'b0;
        wait_left = 2'd0;
        build_program();
        forever begin
            @(posedge clock);
            #1;
            wb_response.ack = 1'b0;
            if (!reset) begin
                pending = 1'b0;
            end else if (wb_request.stb) begin
                if (!pending) begin
                    pending = 1'b1;
                    draw = lfsr_take(2);
                    wait_left = draw[1:0];
                end
                if (wait_left == 2'd0) begin
                    wb_response.ack = 1'b1;
                    wb_response.dat = word_at(wb_request.adr);
                    pending = 1'b0;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= 30 + 8 * trace_length) begin
            $display("timeout: retirement stalled after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b0;
        repeat (4) @(posedge clock);
        #1 reset = 1'b1;
        wait (done == 1'b1);
        repeat (2) @(posedge clock);
        #1;
        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
